//--- sd_pkg.sv
package sd_pkg;

  // Register map
  localparam logic [7:0] ADR_ARGUMENT    = 8'h00;
  localparam logic [7:0] ADR_COMMAND     = 8'h04;
  localparam logic [7:0] ADR_STATUS      = 8'h08;
  localparam logic [7:0] ADR_RESP        = 8'h0C;
  localparam logic [7:0] ADR_BLOCK       = 8'h20;
  localparam logic [7:0] ADR_POWER       = 8'h24;
  localparam logic [7:0] ADR_SOFTWARE    = 8'h28;
  localparam logic [7:0] ADR_TIMEOUT     = 8'h2C;
  localparam logic [7:0] ADR_NORMAL_ISR  = 8'h30;
  localparam logic [7:0] ADR_ERROR_ISR   = 8'h34;
  localparam logic [7:0] ADR_NORMAL_ISER = 8'h38;
  localparam logic [7:0] ADR_ERROR_ISER  = 8'h3C;
  localparam logic [7:0] ADR_CLOCK_D     = 8'h4C;

  // Bus and field widths
  localparam int WB_DW     = 32;
  localparam int WB_AW     = 8;
  localparam int CMD_IDX_W = 6;
  localparam int FRAME_LEN = 48;
  localparam int CRC7_W    = 7;
  localparam int TIMEOUT_W = 16;
  localparam int CLKDIV_W  = 8;
  localparam int ISR_W     = 16;      // Status and enable register width
  localparam int SOFT_W    = 8;

  // Bits covered by the CRC, start bit through argument
  localparam int CRC_BITS = FRAME_LEN - CRC7_W - 1;

  // x^7 + x^3 + 1
  localparam logic [CRC7_W-1:0] CRC7_POLY = 7'h09;

  // Constants
  localparam logic [CLKDIV_W-1:0] RESET_CLK_DIV  = 8'd2;
  localparam logic [15:0]         BLOCK_SIZE_VAL = 16'd512;
  localparam logic [7:0]          POWER_CTRL_VAL = 8'h0F;   // 3.3 V

  // Bit positions
  localparam int CMDSET_RESP_BIT = 6;
  localparam int NISR_CMD_DONE   = 0;
  localparam int EISR_TIMEOUT    = 0;
  localparam int EISR_CRC        = 1;
  localparam int EISR_END        = 2;
  localparam int STATUS_BUSY     = 0;

endpackage

//--- sd_crc7.sv
module sd_crc7 (
  input  logic                      wb_clk_i,
  input  logic                      rst_i,
  input  logic                      clear_i,
  input  logic                      shift_i,
  input  logic                      bit_i,
  output logic [sd_pkg::CRC7_W-1:0] crc_o
);

  logic feedback;

  assign feedback = bit_i ^ crc_o[sd_pkg::CRC7_W-1];

  always_ff @(posedge wb_clk_i or posedge rst_i) begin
    if (rst_i) begin
      crc_o <= '0;
    end else if (clear_i) begin
      crc_o <= '0;
    end else if (shift_i) begin
      // MSB first, polynomial taps on x^3 and x^0
      crc_o <= {crc_o[sd_pkg::CRC7_W-2:0], 1'b0} ^
               ({sd_pkg::CRC7_W{feedback}} & sd_pkg::CRC7_POLY);
    end
  end

endmodule

//--- sd_clk_div.sv
module sd_clk_div (
  input  logic                        wb_clk_i,
  input  logic                        rst_i,
  input  logic [sd_pkg::CLKDIV_W-1:0] divider_i,
  output logic                        sd_clk_o,
  output logic                        sd_rise_o,
  output logic                        sd_fall_o
);

  logic [sd_pkg::CLKDIV_W-1:0] half_cnt;
  logic                        half_end;

  // Compare with >= so a smaller divider takes effect at once
  assign half_end = half_cnt >= divider_i;

  always_ff @(posedge wb_clk_i or posedge rst_i) begin
    if (rst_i) begin
      half_cnt <= '0;
      sd_clk_o <= 1'b0;   // Pad clock idles low
    end else if (half_end) begin
      half_cnt <= '0;
      sd_clk_o <= ~sd_clk_o;
    end else begin
      half_cnt <= half_cnt + 1'b1;
    end
  end

  // Strobes coincide with the edge that changes the pad clock
  assign sd_rise_o = half_end & ~sd_clk_o;
  assign sd_fall_o = half_end & sd_clk_o;

endmodule

//--- sd_cmd_tx.sv
module sd_cmd_tx (
  input  logic                         wb_clk_i,
  input  logic                         rst_i,
  input  logic                         start_i,
  input  logic [sd_pkg::WB_DW-1:0]     arg_i,
  input  logic [sd_pkg::CMD_IDX_W-1:0] idx_i,
  input  logic                         sd_fall_i,
  output logic                         cmd_out_o,
  output logic                         cmd_oe_o,
  output logic                         done_o
);

  logic [sd_pkg::CRC_BITS-1:0] shift_reg;
  logic [5:0]                  bit_cnt;
  logic                        active;
  logic                        crc_shift;
  logic [sd_pkg::CRC7_W-1:0]   crc;

  assign crc_shift = active & sd_fall_i & (bit_cnt < sd_pkg::CRC_BITS);

  sd_crc7 u_crc7 (
    .wb_clk_i (wb_clk_i),
    .rst_i    (rst_i),
    .clear_i  (start_i),
    .shift_i  (crc_shift),
    .bit_i    (shift_reg[sd_pkg::CRC_BITS-1]),
    .crc_o    (crc)
  );

  always_ff @(posedge wb_clk_i or posedge rst_i) begin
    if (rst_i) begin
      bit_cnt   <= '0;
      active    <= 1'b0;
      cmd_out_o <= 1'b1;
      cmd_oe_o  <= 1'b0;
      done_o    <= 1'b0;
    end else begin
      done_o <= 1'b0;
      if (start_i) begin
        active  <= 1'b1;
        bit_cnt <= '0;
      end else if (active && sd_fall_i) begin
        if (bit_cnt == sd_pkg::FRAME_LEN) begin
          active   <= 1'b0;   // End bit has been on the line one SD clock
          cmd_oe_o <= 1'b0;
          done_o   <= 1'b1;
        end else begin
          cmd_oe_o <= 1'b1;
          bit_cnt  <= bit_cnt + 1'b1;
          if (bit_cnt == sd_pkg::CRC_BITS) begin
            cmd_out_o <= crc[sd_pkg::CRC7_W-1];
          end else begin
            cmd_out_o <= shift_reg[sd_pkg::CRC_BITS-1];
          end
        end
      end
    end
  end

  // Start, transmission bit, index, argument; then CRC and end bit refill the top
  always_ff @(posedge wb_clk_i) begin
    if (start_i) begin
      shift_reg <= {1'b0, 1'b1, idx_i, arg_i};
    end else if (active && sd_fall_i) begin
      if (bit_cnt == sd_pkg::CRC_BITS) begin
        shift_reg <= {crc[sd_pkg::CRC7_W-2:0], 1'b1,
                      {(sd_pkg::CRC_BITS - sd_pkg::CRC7_W){1'b0}}};
      end else begin
        shift_reg <= shift_reg << 1;
      end
    end
  end

endmodule

//--- sd_cmd_rx.sv
module sd_cmd_rx (
  input  logic                         wb_clk_i,
  input  logic                         rst_i,
  input  logic                         arm_i,
  input  logic                         tx_done_i,
  input  logic [sd_pkg::TIMEOUT_W-1:0] timeout_i,
  input  logic                         sd_rise_i,
  input  logic                         cmd_in_i,
  output logic                         done_o,
  output logic                         timeout_err_o,
  output logic                         crc_err_o,
  output logic                         end_err_o,
  output logic [sd_pkg::WB_DW-1:0]     status_o
);

  typedef enum logic [1:0] {S_IDLE, S_ARMED, S_WAIT, S_CAPT} state_t;

  state_t                       state;
  logic [sd_pkg::FRAME_LEN-2:0] shift_reg;   // Everything but the end bit
  logic [5:0]                   bit_cnt;
  logic [sd_pkg::TIMEOUT_W-1:0] tick_cnt;
  logic                         crc_shift;
  logic                         last_bit;
  logic [sd_pkg::CRC7_W-1:0]    crc;

  assign crc_shift = sd_rise_i & (((state == S_WAIT) & ~cmd_in_i) |
                                  ((state == S_CAPT) & (bit_cnt < sd_pkg::CRC_BITS)));
  assign last_bit  = (state == S_CAPT) & sd_rise_i & (bit_cnt == sd_pkg::FRAME_LEN - 1);

  sd_crc7 u_crc7 (
    .wb_clk_i (wb_clk_i),
    .rst_i    (rst_i),
    .clear_i  (state == S_ARMED),
    .shift_i  (crc_shift),
    .bit_i    (cmd_in_i),
    .crc_o    (crc)
  );

  always_ff @(posedge wb_clk_i or posedge rst_i) begin
    if (rst_i) begin
      state         <= S_IDLE;
      bit_cnt       <= '0;
      tick_cnt      <= '0;
      done_o        <= 1'b0;
      timeout_err_o <= 1'b0;
      crc_err_o     <= 1'b0;
      end_err_o     <= 1'b0;
    end else begin
      done_o <= 1'b0;
      case (state)
        S_IDLE:  if (arm_i) state <= S_ARMED;
        S_ARMED: begin
          if (tx_done_i) begin
            state    <= S_WAIT;
            tick_cnt <= '0;
          end
        end
        S_WAIT: begin
          if (sd_rise_i) begin
            if (!cmd_in_i) begin          // Start bit
              state   <= S_CAPT;
              bit_cnt <= 6'd1;
            end else if (tick_cnt == timeout_i) begin
              state         <= S_IDLE;
              done_o        <= 1'b1;
              timeout_err_o <= 1'b1;
              crc_err_o     <= 1'b0;
              end_err_o     <= 1'b0;
            end else begin
              tick_cnt <= tick_cnt + 1'b1;
            end
          end
        end
        S_CAPT: begin
          if (sd_rise_i) begin
            bit_cnt <= bit_cnt + 1'b1;
          end
          if (last_bit) begin
            state         <= S_IDLE;
            done_o        <= 1'b1;
            timeout_err_o <= 1'b0;
            crc_err_o     <= shift_reg[sd_pkg::CRC7_W-1:0] != crc;
            end_err_o     <= ~cmd_in_i;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (sd_rise_i && (state == S_WAIT || state == S_CAPT)) begin
      shift_reg <= {shift_reg[sd_pkg::FRAME_LEN-3:0], cmd_in_i};
    end
    if (last_bit) begin
      status_o <= shift_reg[sd_pkg::CRC_BITS-2 -: sd_pkg::WB_DW];   // Frame bits [39:8]
    end
  end

endmodule

//--- sd_cmd_regs.sv
module sd_cmd_regs (
  input  logic                         wb_clk_i,
  input  logic                         wb_rst_i,
  input  logic [sd_pkg::WB_AW-1:0]     wb_adr_i,
  input  logic [sd_pkg::WB_DW-1:0]     wb_dat_i,
  input  logic                         wb_we_i,
  input  logic                         wb_cyc_i,
  input  logic                         wb_stb_i,
  input  logic                         cmd_done_i,
  input  logic                         rsp_done_i,
  input  logic                         rsp_timeout_i,
  input  logic                         rsp_crc_err_i,
  input  logic                         rsp_end_err_i,
  input  logic [sd_pkg::WB_DW-1:0]     rsp_status_i,
  output logic                         wb_ack_o,
  output logic [sd_pkg::WB_DW-1:0]     wb_dat_o,
  output logic                         cmd_start_o,
  output logic [sd_pkg::WB_DW-1:0]     cmd_arg_o,
  output logic [sd_pkg::CMD_IDX_W-1:0] cmd_idx_o,
  output logic                         resp_expected_o,
  output logic [sd_pkg::TIMEOUT_W-1:0] timeout_o,
  output logic [sd_pkg::CLKDIV_W-1:0]  clock_div_o,
  output logic                         soft_rst_o,
  output logic                         int_o
);

  logic [sd_pkg::WB_DW-1:0]     argument_reg;
  logic [sd_pkg::CMD_IDX_W:0]   cmd_set_reg;     // Response flag and index
  logic [sd_pkg::TIMEOUT_W-1:0] timeout_reg;
  logic [sd_pkg::CLKDIV_W-1:0]  clock_div_reg;
  logic [sd_pkg::SOFT_W-1:0]    software_reg;
  logic [sd_pkg::ISR_W-1:0]     nisr;
  logic [sd_pkg::ISR_W-1:0]     eisr;
  logic [sd_pkg::ISR_W-1:0]     niser;
  logic [sd_pkg::ISR_W-1:0]     eiser;
  logic [sd_pkg::ISR_W-1:0]     status_reg;
  logic [sd_pkg::WB_DW-1:0]     resp_reg;
  logic                         busy;
  logic                         resp_pend;       // Response expected for the running command
  logic                         wb_req;
  logic                         wr_en;
  logic                         cmd_end;

  assign wb_req  = wb_cyc_i & wb_stb_i & ~wb_ack_o;
  assign wr_en   = wb_req & wb_we_i;
  assign cmd_end = (cmd_done_i & ~resp_pend) | rsp_done_i;

  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      wb_ack_o <= 1'b0;
    end else begin
      wb_ack_o <= wb_req;   // Single cycle, no wait states
    end
  end

  // Host writable registers
  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      argument_reg  <= '0;
      cmd_set_reg   <= '0;
      timeout_reg   <= '0;
      clock_div_reg <= sd_pkg::RESET_CLK_DIV;
      software_reg  <= '0;
      niser         <= '0;
      eiser         <= '0;
    end else if (wr_en) begin
      case (wb_adr_i)
        sd_pkg::ADR_ARGUMENT:    argument_reg  <= wb_dat_i;
        sd_pkg::ADR_COMMAND:     cmd_set_reg   <= wb_dat_i[sd_pkg::CMD_IDX_W:0];
        sd_pkg::ADR_SOFTWARE:    software_reg  <= wb_dat_i[sd_pkg::SOFT_W-1:0];
        sd_pkg::ADR_TIMEOUT:     timeout_reg   <= wb_dat_i[sd_pkg::TIMEOUT_W-1:0];
        sd_pkg::ADR_NORMAL_ISER: niser         <= wb_dat_i[sd_pkg::ISR_W-1:0];
        sd_pkg::ADR_ERROR_ISER:  eiser         <= wb_dat_i[sd_pkg::ISR_W-1:0];
        sd_pkg::ADR_CLOCK_D:     clock_div_reg <= wb_dat_i[sd_pkg::CLKDIV_W-1:0];
        default: ;
      endcase
    end
  end

  // Command sequencing, a write while busy starts nothing
  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      busy        <= 1'b0;
      resp_pend   <= 1'b0;
      cmd_start_o <= 1'b0;
    end else begin
      cmd_start_o <= 1'b0;
      if (software_reg[0]) begin
        busy      <= 1'b0;
        resp_pend <= 1'b0;
      end else if (wr_en && wb_adr_i == sd_pkg::ADR_COMMAND && !busy) begin
        busy        <= 1'b1;
        cmd_start_o <= 1'b1;
        resp_pend   <= wb_dat_i[sd_pkg::CMDSET_RESP_BIT];
      end else if (cmd_end) begin
        busy <= 1'b0;
      end
    end
  end

  // Interrupt status, write 1 to clear; a new event wins over the clear
  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      nisr <= '0;
      eisr <= '0;
    end else begin
      if (wr_en && wb_adr_i == sd_pkg::ADR_NORMAL_ISR) begin
        nisr <= nisr & ~wb_dat_i[sd_pkg::ISR_W-1:0];
      end
      if (wr_en && wb_adr_i == sd_pkg::ADR_ERROR_ISR) begin
        eisr <= eisr & ~wb_dat_i[sd_pkg::ISR_W-1:0];
      end
      if (cmd_end) begin
        nisr[sd_pkg::NISR_CMD_DONE] <= 1'b1;
      end
      if (rsp_done_i) begin
        eisr[sd_pkg::EISR_TIMEOUT] <= eisr[sd_pkg::EISR_TIMEOUT] | rsp_timeout_i;
        eisr[sd_pkg::EISR_CRC]     <= eisr[sd_pkg::EISR_CRC] | rsp_crc_err_i;
        eisr[sd_pkg::EISR_END]     <= eisr[sd_pkg::EISR_END] | rsp_end_err_i;
      end
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (rsp_done_i && !rsp_timeout_i) begin
      resp_reg <= rsp_status_i;   // Card status bits [39:8]
    end
  end

  always_comb begin
    status_reg = '0;
    status_reg[sd_pkg::STATUS_BUSY] = busy;
  end

  // Read data lines up with ack
  always_ff @(posedge wb_clk_i) begin
    if (wb_req) begin
      case (wb_adr_i)
        sd_pkg::ADR_ARGUMENT:    wb_dat_o <= argument_reg;
        sd_pkg::ADR_COMMAND:     wb_dat_o <= {25'h0, cmd_set_reg};
        sd_pkg::ADR_STATUS:      wb_dat_o <= {16'h0, status_reg};
        sd_pkg::ADR_RESP:        wb_dat_o <= resp_reg;
        sd_pkg::ADR_BLOCK:       wb_dat_o <= {16'h0, sd_pkg::BLOCK_SIZE_VAL};
        sd_pkg::ADR_POWER:       wb_dat_o <= {24'h0, sd_pkg::POWER_CTRL_VAL};
        sd_pkg::ADR_SOFTWARE:    wb_dat_o <= {24'h0, software_reg};
        sd_pkg::ADR_TIMEOUT:     wb_dat_o <= {16'h0, timeout_reg};
        sd_pkg::ADR_NORMAL_ISR:  wb_dat_o <= {16'h0, nisr};
        sd_pkg::ADR_ERROR_ISR:   wb_dat_o <= {16'h0, eisr};
        sd_pkg::ADR_NORMAL_ISER: wb_dat_o <= {16'h0, niser};
        sd_pkg::ADR_ERROR_ISER:  wb_dat_o <= {16'h0, eiser};
        sd_pkg::ADR_CLOCK_D:     wb_dat_o <= {24'h0, clock_div_reg};
        default:                 wb_dat_o <= '0;
      endcase
    end
  end

  assign cmd_arg_o       = argument_reg;
  assign cmd_idx_o       = cmd_set_reg[sd_pkg::CMD_IDX_W-1:0];
  assign resp_expected_o = cmd_set_reg[sd_pkg::CMDSET_RESP_BIT];
  assign timeout_o       = timeout_reg;
  assign clock_div_o     = clock_div_reg;
  assign soft_rst_o      = software_reg[0];
  assign int_o           = |(nisr & niser) | |(eisr & eiser);

endmodule

//--- sd_ctrl_top.sv
module sd_ctrl_top (
  input  logic                     wb_clk_i,
  input  logic                     wb_rst_i,
  input  logic [sd_pkg::WB_AW-1:0] wb_adr_i,
  input  logic [sd_pkg::WB_DW-1:0] wb_dat_i,
  input  logic [3:0]               wb_sel_i,   // Full-word access only
  input  logic                     wb_we_i,
  input  logic                     wb_cyc_i,
  input  logic                     wb_stb_i,
  output logic                     wb_ack_o,
  output logic [sd_pkg::WB_DW-1:0] wb_dat_o,
  input  logic                     sd_cmd_dat_i,
  output logic                     sd_cmd_out_o,
  output logic                     sd_cmd_oe_o,
  output logic                     sd_clk_o_pad,
  output logic                     int_o
);

  logic                         core_rst;
  logic                         soft_rst;
  logic                         sd_rise;
  logic                         sd_fall;
  logic                         cmd_start;
  logic [sd_pkg::WB_DW-1:0]     cmd_arg;
  logic [sd_pkg::CMD_IDX_W-1:0] cmd_idx;
  logic                         resp_expected;
  logic [sd_pkg::TIMEOUT_W-1:0] timeout;
  logic [sd_pkg::CLKDIV_W-1:0]  clock_div;
  logic                         cmd_done;
  logic                         rsp_done;
  logic                         rsp_timeout;
  logic                         rsp_crc_err;
  logic                         rsp_end_err;
  logic [sd_pkg::WB_DW-1:0]     rsp_status;
  logic                         rx_arm;

  assign core_rst = wb_rst_i | soft_rst;  // Software reset bit 0 holds the command logic
  assign rx_arm   = cmd_start & resp_expected;

  sd_cmd_regs u_regs (
    .wb_clk_i        (wb_clk_i),
    .wb_rst_i        (wb_rst_i),
    .wb_adr_i        (wb_adr_i),
    .wb_dat_i        (wb_dat_i),
    .wb_we_i         (wb_we_i),
    .wb_cyc_i        (wb_cyc_i),
    .wb_stb_i        (wb_stb_i),
    .cmd_done_i      (cmd_done),
    .rsp_done_i      (rsp_done),
    .rsp_timeout_i   (rsp_timeout),
    .rsp_crc_err_i   (rsp_crc_err),
    .rsp_end_err_i   (rsp_end_err),
    .rsp_status_i    (rsp_status),
    .wb_ack_o        (wb_ack_o),
    .wb_dat_o        (wb_dat_o),
    .cmd_start_o     (cmd_start),
    .cmd_arg_o       (cmd_arg),
    .cmd_idx_o       (cmd_idx),
    .resp_expected_o (resp_expected),
    .timeout_o       (timeout),
    .clock_div_o     (clock_div),
    .soft_rst_o      (soft_rst),
    .int_o           (int_o)
  );

  sd_clk_div u_clk_div (
    .wb_clk_i  (wb_clk_i),
    .rst_i     (core_rst),
    .divider_i (clock_div),
    .sd_clk_o  (sd_clk_o_pad),
    .sd_rise_o (sd_rise),
    .sd_fall_o (sd_fall)
  );

  sd_cmd_tx u_cmd_tx (
    .wb_clk_i  (wb_clk_i),
    .rst_i     (core_rst),
    .start_i   (cmd_start),
    .arg_i     (cmd_arg),
    .idx_i     (cmd_idx),
    .sd_fall_i (sd_fall),
    .cmd_out_o (sd_cmd_out_o),
    .cmd_oe_o  (sd_cmd_oe_o),
    .done_o    (cmd_done)
  );

  sd_cmd_rx u_cmd_rx (
    .wb_clk_i      (wb_clk_i),
    .rst_i         (core_rst),
    .arm_i         (rx_arm),
    .tx_done_i     (cmd_done),
    .timeout_i     (timeout),
    .sd_rise_i     (sd_rise),
    .cmd_in_i      (sd_cmd_dat_i),
    .done_o        (rsp_done),
    .timeout_err_o (rsp_timeout),
    .crc_err_o     (rsp_crc_err),
    .end_err_o     (rsp_end_err),
    .status_o      (rsp_status)
  );

endmodule

//--- tb_sd_card.sv
module tb_sd_card (
  input  logic        sd_clk_i,
  input  logic        cmd_i,
  input  logic        cmd_oe_i,
  input  logic        silent_i,     // Never answer
  input  logic        bad_crc_i,    // Answer with an inverted CRC
  output logic        cmd_o,
  output logic [7:0]  frame_cnt_o,
  output logic [5:0]  last_idx_o,
  output logic [31:0] last_arg_o,
  output logic        crc_ok_o
);

  event got_frame;

  // CRC7 x^7 + x^3 + 1, first bit at the MSB
  function automatic logic [6:0] crc7(input logic [39:0] bits);
    logic [6:0] c;
    logic       fb;
    c = 7'h00;
    for (int i = 39; i >= 0; i--) begin
      fb = bits[i] ^ c[6];
      c  = {c[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
    end
    return c;
  endfunction

  // Host changes CMD on the falling edge, card samples on the rising edge
  initial begin
    logic [47:0] frame;
    logic [5:0]  bit_cnt;
    frame       = '0;
    bit_cnt     = '0;
    frame_cnt_o = '0;
    last_idx_o  = '0;
    last_arg_o  = '0;
    crc_ok_o    = 1'b0;
    forever begin
      @(posedge sd_clk_i);
      if (cmd_oe_i) begin
        frame   = {frame[46:0], cmd_i};
        bit_cnt = bit_cnt + 6'd1;
        if (bit_cnt == 6'd48) begin
          bit_cnt     = '0;
          frame_cnt_o = frame_cnt_o + 8'd1;
          last_idx_o  = frame[45:40];
          last_arg_o  = frame[39:8];
          crc_ok_o    = (frame[47:46] == 2'b01) && (frame[7:1] == crc7(frame[47:8])) && frame[0];
          -> got_frame;
        end
      end
    end
  end

  // R1 style answer, two SD clocks after the end bit
  initial begin
    logic [47:0] rsp;
    cmd_o = 1'b1;
    forever begin
      @(got_frame);
      if (!silent_i) begin
        rsp[47:8] = {2'b00, last_idx_o, last_arg_o ^ 32'hA5A5_5A5A};
        rsp[7:0]  = {crc7(rsp[47:8]) ^ (bad_crc_i ? 7'h7F : 7'h00), 1'b1};
        repeat (2) @(negedge sd_clk_i);
        for (int i = 47; i >= 0; i--) begin
          @(negedge sd_clk_i);
          cmd_o <= rsp[i];
        end
      end
    end
  end

endmodule

//--- tb_sd_ctrl.sv
module tb_sd_ctrl;

  // Five tests of up to four commands at 110 SD clocks each on the slowest divider
  localparam int MAX_CYCLES = 40000;
  localparam logic [31:0] RSP_XOR = 32'hA5A5_5A5A;

  logic        wb_clk_i;
  logic        wb_rst_i;
  logic [7:0]  wb_adr_i;
  logic [31:0] wb_dat_i;
  logic [3:0]  wb_sel_i;
  logic        wb_we_i;
  logic        wb_cyc_i;
  logic        wb_stb_i;
  logic        wb_ack_o;
  logic [31:0] wb_dat_o;
  logic        sd_cmd_dat;
  logic        sd_cmd_out;
  logic        sd_cmd_oe;
  logic        sd_clk;
  logic        int_o;
  logic        card_silent;
  logic        card_bad_crc;
  logic [7:0]  card_frames;
  logic [5:0]  card_idx;
  logic [31:0] card_arg;
  logic        card_crc_ok;
  int          errors;
  int          tests_failed;
  int          seed;
  int          cycles;

  sd_ctrl_top u_dut (
    .wb_clk_i     (wb_clk_i),
    .wb_rst_i     (wb_rst_i),
    .wb_adr_i     (wb_adr_i),
    .wb_dat_i     (wb_dat_i),
    .wb_sel_i     (wb_sel_i),
    .wb_we_i      (wb_we_i),
    .wb_cyc_i     (wb_cyc_i),
    .wb_stb_i     (wb_stb_i),
    .wb_ack_o     (wb_ack_o),
    .wb_dat_o     (wb_dat_o),
    .sd_cmd_dat_i (sd_cmd_dat),
    .sd_cmd_out_o (sd_cmd_out),
    .sd_cmd_oe_o  (sd_cmd_oe),
    .sd_clk_o_pad (sd_clk),
    .int_o        (int_o)
  );

  tb_sd_card u_card (
    .sd_clk_i    (sd_clk),
    .cmd_i       (sd_cmd_out),
    .cmd_oe_i    (sd_cmd_oe),
    .silent_i    (card_silent),
    .bad_crc_i   (card_bad_crc),
    .cmd_o       (sd_cmd_dat),
    .frame_cnt_o (card_frames),
    .last_idx_o  (card_idx),
    .last_arg_o  (card_arg),
    .crc_ok_o    (card_crc_ok)
  );

  initial begin
    wb_clk_i = 1'b0;
    forever #2 wb_clk_i = ~wb_clk_i;
  end

  initial begin
    cycles = 0;
    forever begin
      @(posedge wb_clk_i);
      cycles = cycles + 1;
      if (cycles >= MAX_CYCLES) begin
        $display("Run did not finish within %0d clock cycles", MAX_CYCLES);
        $display("STATUS: FAIL");
        $finish;
      end
    end
  end

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAIL %s: got 0x%08h expected 0x%08h", name, got, exp);
      errors++;
    end
  endtask

  task automatic wb_access(input logic [7:0] adr, input logic [31:0] dat, input logic we,
                           output logic [31:0] rd);
    int n;
    n = 0;
    @(negedge wb_clk_i);
    wb_adr_i = adr;
    wb_dat_i = dat;
    wb_we_i  = we;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    while (wb_ack_o !== 1'b1 && n < 16) begin
      @(negedge wb_clk_i);
      n++;
    end
    if (wb_ack_o !== 1'b1) begin
      $display("Wishbone access to 0x%02h was never acknowledged", adr);
      errors++;
    end
    rd       = wb_dat_o;   // Valid while ack is high
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  task automatic wb_write(input logic [7:0] adr, input logic [31:0] dat);
    logic [31:0] unused;
    wb_access(adr, dat, 1'b1, unused);
  endtask

  task automatic wb_read(input logic [7:0] adr, output logic [31:0] dat);
    wb_access(adr, 32'h0, 1'b0, dat);
  endtask

  task automatic read_expect(input string name, input logic [7:0] adr, input logic [31:0] exp);
    logic [31:0] rd;
    wb_read(adr, rd);
    check_eq(name, rd, exp);
  endtask

  task automatic send_cmd(input logic [5:0] idx, input logic [31:0] arg, input logic resp);
    wb_write(sd_pkg::ADR_ARGUMENT, arg);
    wb_write(sd_pkg::ADR_COMMAND, {25'h0, resp, idx});
  endtask

  // Poll the busy bit until the command has ended
  task automatic wait_idle();
    logic [31:0] st;
    int polls;
    polls = 0;
    wb_read(sd_pkg::ADR_STATUS, st);
    while (st[sd_pkg::STATUS_BUSY] && polls < 5000) begin
      wb_read(sd_pkg::ADR_STATUS, st);
      polls++;
    end
    if (st[sd_pkg::STATUS_BUSY]) begin
      $display("Command still busy after %0d status polls", polls);
      errors++;
    end
  endtask

  task automatic clear_isr();
    wb_write(sd_pkg::ADR_NORMAL_ISR, 32'h0000_FFFF);
    wb_write(sd_pkg::ADR_ERROR_ISR, 32'h0000_FFFF);
  endtask

  task automatic end_test(input string name, input int err_before);
    if (errors == err_before) begin
      $display("%-14s passed", name);
    end else begin
      $display("%-14s failed with %0d errors", name, errors - err_before);
      tests_failed++;
    end
  endtask

  task automatic test_reset_values();
    int e0;
    e0 = errors;
    read_expect("clock_div", sd_pkg::ADR_CLOCK_D, 32'd2);
    read_expect("block_size", sd_pkg::ADR_BLOCK, 32'd512);
    read_expect("power", sd_pkg::ADR_POWER, 32'h0000_000F);
    read_expect("status", sd_pkg::ADR_STATUS, 32'h0);
    check_eq("int_o", {31'h0, int_o}, 32'h0);
    wb_write(sd_pkg::ADR_ARGUMENT, 32'h1234_5678);
    read_expect("argument", sd_pkg::ADR_ARGUMENT, 32'h1234_5678);
    wb_write(sd_pkg::ADR_TIMEOUT, 32'h0000_BEEF);
    read_expect("timeout", sd_pkg::ADR_TIMEOUT, 32'h0000_BEEF);
    wb_write(sd_pkg::ADR_NORMAL_ISER, 32'h0000_00A5);
    read_expect("normal_iser", sd_pkg::ADR_NORMAL_ISER, 32'h0000_00A5);
    wb_write(sd_pkg::ADR_ERROR_ISER, 32'h0000_5A5A);
    read_expect("error_iser", sd_pkg::ADR_ERROR_ISER, 32'h0000_5A5A);
    wb_write(sd_pkg::ADR_NORMAL_ISER, 32'h0);
    wb_write(sd_pkg::ADR_ERROR_ISER, 32'h0);
    wb_write(sd_pkg::ADR_TIMEOUT, 32'd64);   // Room for the card's answer
    end_test("reset_values", e0);
  endtask

  task automatic test_cmd_no_resp();
    int          e0;
    logic [31:0] arg;
    logic [7:0]  frames0;
    e0          = errors;
    frames0     = card_frames;
    card_silent = 1'b1;
    arg         = $random(seed);
    send_cmd(6'd17, arg, 1'b0);
    read_expect("busy", sd_pkg::ADR_STATUS, 32'h1);
    wait_idle();
    check_eq("card_frames", {24'h0, card_frames}, {24'h0, frames0 + 8'd1});
    check_eq("card_idx", {26'h0, card_idx}, 32'd17);
    check_eq("card_arg", card_arg, arg);
    check_eq("card_crc_ok", {31'h0, card_crc_ok}, 32'h1);
    read_expect("normal_isr", sd_pkg::ADR_NORMAL_ISR, 32'h1 << sd_pkg::NISR_CMD_DONE);
    read_expect("error_isr", sd_pkg::ADR_ERROR_ISR, 32'h0);
    clear_isr();
    end_test("cmd_no_resp", e0);
  endtask

  task automatic test_cmd_resp();
    int          e0;
    logic [31:0] arg;
    e0          = errors;
    card_silent = 1'b0;
    arg         = $random(seed);
    wb_write(sd_pkg::ADR_NORMAL_ISER, 32'h1);
    send_cmd(6'd8, arg, 1'b1);
    wait_idle();
    read_expect("resp", sd_pkg::ADR_RESP, arg ^ RSP_XOR);
    read_expect("normal_isr", sd_pkg::ADR_NORMAL_ISR, 32'h1 << sd_pkg::NISR_CMD_DONE);
    read_expect("error_isr", sd_pkg::ADR_ERROR_ISR, 32'h0);
    check_eq("int_o", {31'h0, int_o}, 32'h1);
    wb_write(sd_pkg::ADR_NORMAL_ISR, 32'h1);
    check_eq("int_o", {31'h0, int_o}, 32'h0);   // Clear lands on the ack edge
    wb_write(sd_pkg::ADR_NORMAL_ISER, 32'h0);
    end_test("cmd_resp", e0);
  endtask

  task automatic test_rsp_errors();
    int          e0;
    logic [31:0] arg;
    e0          = errors;
    arg         = $random(seed);
    card_silent = 1'b1;
    wb_write(sd_pkg::ADR_TIMEOUT, 32'd20);
    send_cmd(6'd13, arg, 1'b1);
    read_expect("busy", sd_pkg::ADR_STATUS, 32'h1);
    wait_idle();
    read_expect("error_isr", sd_pkg::ADR_ERROR_ISR, 32'h1 << sd_pkg::EISR_TIMEOUT);
    clear_isr();
    card_silent  = 1'b0;
    card_bad_crc = 1'b1;
    wb_write(sd_pkg::ADR_TIMEOUT, 32'd64);
    send_cmd(6'd13, arg, 1'b1);
    wait_idle();
    read_expect("error_isr", sd_pkg::ADR_ERROR_ISR, 32'h1 << sd_pkg::EISR_CRC);
    card_bad_crc = 1'b0;
    clear_isr();
    end_test("rsp_errors", e0);
  endtask

  task automatic test_divider();
    int          e0;
    logic [31:0] arg;
    logic [7:0]  frames0;
    e0 = errors;
    for (int i = 0; i < 2; i++) begin
      wb_write(sd_pkg::ADR_CLOCK_D, (i == 0) ? 32'd0 : 32'd5);
      frames0 = card_frames;
      arg     = $random(seed);
      send_cmd(6'd55, arg, 1'b1);
      wb_write(sd_pkg::ADR_COMMAND, {25'h0, 1'b1, 6'd2});   // Lands while busy
      wait_idle();
      read_expect("resp", sd_pkg::ADR_RESP, arg ^ RSP_XOR);
      read_expect("error_isr", sd_pkg::ADR_ERROR_ISR, 32'h0);
      check_eq("card_frames", {24'h0, card_frames}, {24'h0, frames0 + 8'd1});
      check_eq("card_idx", {26'h0, card_idx}, 32'd55);
      clear_isr();
    end
    wb_write(sd_pkg::ADR_CLOCK_D, 32'd2);
    end_test("divider", e0);
  endtask

  initial begin
    seed         = 89;
    errors       = 0;
    tests_failed = 0;
    wb_rst_i     = 1'b1;
    wb_adr_i     = 8'h0;
    wb_dat_i     = 32'h0;
    wb_sel_i     = 4'hF;
    wb_we_i      = 1'b0;
    wb_cyc_i     = 1'b0;
    wb_stb_i     = 1'b0;
    card_silent  = 1'b0;
    card_bad_crc = 1'b0;
    repeat (10) @(posedge wb_clk_i);
    @(negedge wb_clk_i);
    wb_rst_i = 1'b0;
    test_reset_values();
    test_cmd_no_resp();
    test_cmd_resp();
    test_rsp_errors();
    test_divider();
    $display("Tests run 5, tests failed %0d, check errors %0d", tests_failed, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

//--- vlog.f
sd_pkg.sv
sd_crc7.sv
sd_clk_div.sv
sd_cmd_tx.sv
sd_cmd_rx.sv
sd_cmd_regs.sv
sd_ctrl_top.sv
tb_sd_card.sv
tb_sd_ctrl.sv

//--- run.sh
#!/bin/sh
# Build with Verilator and run; success only if the pass line is printed
cd "$(dirname "$0")" || exit 1
verilator --binary -j 0 --top-module tb_sd_ctrl -f vlog.f &&
  ./obj_dir/Vtb_sd_ctrl | tee /dev/stderr | grep -q "^STATUS: PASS$" &&
  echo "run.sh: simulation passed" ||
  { echo "run.sh: simulation failed"; exit 1; }
